// ==== src.f ====
+incdir+test
source/fib_pkg.sv
source/fib_prefix_hash.sv
source/fib_rx_parser.sv
source/fib_valid_table.sv
source/fib_lpm_search.sv
source/fib_tx_serializer.sv
source/fib_table.sv
test/fib_table_tb.sv

// ==== Makefile ====
# Verilator build and run of the forwarding table testbench

VERILATOR ?= verilator
TOP       ?= fib_table_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== test/fib_model.svh ====
// Reference model for the forwarding table testbench
// Hash rule, set of learned length and hash pairs
// Longest-prefix walk and the predicted 17-byte reply

`ifndef FIB_MODEL_SVH
`define FIB_MODEL_SVH

// One flag per learned (length, hash) pair
bit    learned_set [NUM_LENGTHS][TABLE_DEPTH];
// Reply bytes for the lookup in flight, in send order
byte_t expected_reply [$];

// Seven 10-bit chunks from bit 0 upward, top chunk zero-padded, all XORed
function automatic hash_t hash_rule(input prefix_t p);
    logic [7*HASH_W-1:0] padded;
    hash_t               acc;
    padded = {{(7*HASH_W-PREFIX_W){1'b0}}, p};
    acc    = '0;
    for (int c = 0; c < 7; c++) begin
        acc = acc ^ padded[c*HASH_W +: HASH_W];
    end
    return acc;
endfunction

// Learning marks the packet's own length and the hash of its full prefix
function automatic void learn_entry(input byte_t meta, input prefix_t p);
    learned_set[meta[META_LEN_MSB:META_LEN_LSB]][hash_rule(p)] = 1'b1;
endfunction

// Miss clears the bit at the current length and shortens by one
// Stops on a hit or at length zero
function automatic prefix_t lookup_walk(input prefix_t p, input byte_t meta);
    prefix_t cur;
    len_t    len;
    cur = p;
    len = meta[META_LEN_MSB:META_LEN_LSB];
    while (!learned_set[len][hash_rule(cur)] && len != '0) begin
        cur[len] = 1'b0;
        len      = len - len_t'(1);
    end
    return cur;
endfunction

// Metadata, then total prefix, then matched prefix, MSB byte first
function automatic void predict_reply(input byte_t meta, input prefix_t p);
    prefix_t m;
    m = lookup_walk(p, meta);
    expected_reply.delete();
    expected_reply.push_back(meta);
    for (int i = PREFIX_BYTES - 1; i >= 0; i--) begin
        expected_reply.push_back(p[i*BYTE_W +: BYTE_W]);
    end
    for (int i = PREFIX_BYTES - 1; i >= 0; i--) begin
        expected_reply.push_back(m[i*BYTE_W +: BYTE_W]);
    end
endfunction

`endif

// ==== test/fib_table_tb.sv ====
// Testbench for the NDN forwarding table
// Clock, reset, random learning packets and lookups
// Output monitors, compare tasks, watchdog

`timescale 1ns/1ps

module fib_table_tb;

    import fib_pkg::*;

    `include "fib_model.svh"

    localparam logic [31:0] SEED = 32'h2dfbd8d6;
    localparam int CLK_PERIOD     = 10;
    localparam int RESET_CYCLES   = 5;
    // Packet and lookup counts
    localparam int N_EMPTY        = 4;
    localparam int N_RANDOM_LEARN = 12;
    localparam int N_SHORT_LEARN  = 12;
    localparam int N_RANDOM_LOOK  = 8;
    localparam int N_PACKETS      = N_RANDOM_LEARN + N_SHORT_LEARN;
    localparam int N_LOOKUPS      = N_EMPTY + N_PACKETS + N_SHORT_LEARN + N_RANDOM_LOOK;
    // Budget of 200 cycles for every packet and every lookup
    localparam int TIMEOUT_NS =
        (RESET_CYCLES + 200 * (N_PACKETS + N_LOOKUPS)) * CLK_PERIOD;

    logic    clk;
    logic    rst;
    logic    rx_valid;
    byte_t   rx_data;
    logic    lookup_start;
    prefix_t pit_in_prefix;
    byte_t   pit_in_metadata;
    logic    prefix_ready;
    prefix_t pit_out_prefix;
    byte_t   pit_out_metadata;
    logic    lookup_busy;
    logic    tx_valid;
    byte_t   tx_data;

    // Captured DUT outputs
    prefix_t announced_prefix [$];
    byte_t   announced_meta [$];
    byte_t   tx_bytes [$];
    // Learned packets and the long queries built on top of them
    prefix_t learned_prefix [$];
    byte_t   learned_meta [$];
    prefix_t long_prefix [$];
    byte_t   long_meta [$];

    fib_table DUT (
        .clk             (clk),
        .rst             (rst),
        .rx_valid        (rx_valid),
        .rx_data         (rx_data),
        .lookup_start    (lookup_start),
        .pit_in_prefix   (pit_in_prefix),
        .pit_in_metadata (pit_in_metadata),
        .prefix_ready    (prefix_ready),
        .pit_out_prefix  (pit_out_prefix),
        .pit_out_metadata(pit_out_metadata),
        .lookup_busy     (lookup_busy),
        .tx_valid        (tx_valid),
        .tx_data         (tx_data)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Outputs are registered and settled by the falling edge
    always @(negedge clk) begin
        if (prefix_ready) begin
            announced_prefix.push_back(pit_out_prefix);
            announced_meta.push_back(pit_out_metadata);
        end
        if (tx_valid) begin
            tx_bytes.push_back(tx_data);
        end
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        abort_run();
    end

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_prefix(input string name, input prefix_t expected,
                                input prefix_t actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %b, actual %b", name, expected, actual);
            abort_run();
        end
    endtask

    // Metadata then prefix bytes MSB first with random gaps between bytes
    // At least three idle cycles after the last byte for hash and write
    task automatic send_packet(input byte_t meta, input prefix_t p);
        byte_t pkt [PREFIX_BYTES+1];
        int    gap;
        pkt[0] = meta;
        for (int i = 0; i < PREFIX_BYTES; i++) begin
            pkt[i+1] = p[(PREFIX_BYTES-1-i)*BYTE_W +: BYTE_W];
        end
        for (int i = 0; i <= PREFIX_BYTES; i++) begin
            rx_valid = 1'b1;
            rx_data  = pkt[i];
            @(negedge clk);
            rx_valid = 1'b0;
            rx_data  = byte_t'($urandom());
            gap = (i < PREFIX_BYTES) ? $urandom_range(2, 0) : $urandom_range(6, 3);
            repeat (gap) @(negedge clk);
        end
        learn_entry(meta, p);
        check_bit("one prefix_ready per packet", 1'b1, announced_prefix.size() == 1);
        check_prefix("pit_out_prefix", p, announced_prefix.pop_front());
        check_byte("pit_out_metadata", meta, announced_meta.pop_front());
    endtask

    // One lookup with an optional second start while busy
    task automatic run_lookup(input string name, input byte_t meta, input prefix_t p,
                              input bit poke_busy);
        while (lookup_busy) @(negedge clk);
        check_byte({name, " stray reply bytes"}, 8'h00, byte_t'(tx_bytes.size()));
        predict_reply(meta, p);
        lookup_start    = 1'b1;
        pit_in_prefix   = p;
        pit_in_metadata = meta;
        @(negedge clk);
        lookup_start = 1'b0;
        check_bit({name, " busy after start"}, 1'b1, lookup_busy);
        if (poke_busy) begin
            repeat ($urandom_range(4, 0)) @(negedge clk);
            if (lookup_busy) begin
                lookup_start    = 1'b1;
                pit_in_prefix   = {$urandom(), $urandom()};
                pit_in_metadata = byte_t'($urandom());
                @(negedge clk);
                lookup_start = 1'b0;
            end
        end
        // Busy drops right after the last reply byte
        while (lookup_busy) @(negedge clk);
        check_byte({name, " reply length"}, byte_t'(TX_BYTES), byte_t'(tx_bytes.size()));
        for (int i = 0; i < TX_BYTES; i++) begin
            check_byte($sformatf("%s reply byte %0d", name, i), expected_reply[i], tx_bytes[i]);
        end
        tx_bytes.delete();
    endtask

    initial begin
        prefix_t q;
        byte_t   m;
        prefix_t p_short;
        byte_t   m_short;
        len_t    long_len;
        len_t    short_len;
        void'($urandom(SEED));
        rst             = 1'b1;
        rx_valid        = 1'b0;
        rx_data         = '0;
        lookup_start    = 1'b0;
        pit_in_prefix   = '0;
        pit_in_metadata = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        check_bit("prefix_ready after reset", 1'b0, prefix_ready);
        check_bit("tx_valid after reset", 1'b0, tx_valid);
        check_bit("lookup_busy after reset", 1'b0, lookup_busy);

        // Every walk on the empty table runs down to length zero
        for (int i = 0; i < N_EMPTY; i++) begin
            run_lookup("empty table lookup", byte_t'($urandom()), {$urandom(), $urandom()},
                       1'b0);
        end

        // Fully random learning packets
        for (int i = 0; i < N_RANDOM_LEARN; i++) begin
            m = byte_t'($urandom());
            q = {$urandom(), $urandom()};
            send_packet(m, q);
            learned_prefix.push_back(q);
            learned_meta.push_back(m);
        end

        // Shortened forms of long queries with bits above the short length cleared
        for (int i = 0; i < N_SHORT_LEARN; i++) begin
            long_len  = len_t'($urandom_range(NUM_LENGTHS - 1, 2));
            short_len = len_t'($urandom_range(int'(long_len) - 1, 0));
            q = {$urandom(), $urandom()};
            m = byte_t'($urandom());
            m[META_LEN_MSB:META_LEN_LSB] = long_len;
            p_short = q;
            for (int b = int'(short_len) + 1; b <= int'(long_len); b++) begin
                p_short[b] = 1'b0;
            end
            m_short = m;
            m_short[META_LEN_MSB:META_LEN_LSB] = short_len;
            send_packet(m_short, p_short);
            learned_prefix.push_back(p_short);
            learned_meta.push_back(m_short);
            long_prefix.push_back(q);
            long_meta.push_back(m);
        end

        // Own-length lookups hit at once
        foreach (learned_prefix[i]) begin
            run_lookup("learned prefix lookup", learned_meta[i], learned_prefix[i],
                       (i % 2) == 1);
        end
        // Long queries walk down to their learned short form or earlier
        foreach (long_prefix[i]) begin
            run_lookup("long prefix lookup", long_meta[i], long_prefix[i], (i % 2) == 0);
        end
        for (int i = 0; i < N_RANDOM_LOOK; i++) begin
            run_lookup("random lookup", byte_t'($urandom()), {$urandom(), $urandom()}, 1'b1);
        end

        // Ignored starts must not leave a late reply behind
        repeat (20) @(negedge clk);
        check_byte("stray reply bytes at end", 8'h00, byte_t'(tx_bytes.size()));
        check_bit("lookup_busy at end", 1'b0, lookup_busy);
        check_byte("stray prefix_ready at end", 8'h00, byte_t'(announced_prefix.size()));
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== source/fib_table.sv ====
// Forwarding table top level
// Receive parser with learning, valid-bit table
// Longest-prefix search and reply serializer

`timescale 1ns/1ps

module fib_table (
    input  logic             clk,
    input  logic             rst,
    input  logic             rx_valid,
    input  fib_pkg::byte_t   rx_data,
    input  logic             lookup_start,
    input  fib_pkg::prefix_t pit_in_prefix,
    input  fib_pkg::byte_t   pit_in_metadata,
    output logic             prefix_ready,
    output fib_pkg::prefix_t pit_out_prefix,
    output fib_pkg::byte_t   pit_out_metadata,
    output logic             lookup_busy,
    output logic             tx_valid,
    output fib_pkg::byte_t   tx_data
);

    import fib_pkg::*;

    // Learning path
    logic    learn_we;
    len_t    learn_len;
    hash_t   learn_hash;

    // Search to table read port
    len_t    rd_len;
    hash_t   rd_hash;
    logic    rd_hit;

    // Search to serializer
    logic    emit_start;
    prefix_t total_prefix;
    prefix_t match_prefix;
    byte_t   match_metadata;
    logic    tx_done;

    fib_rx_parser u_rx_parser (
        .clk             (clk),
        .rst             (rst),
        .rx_valid        (rx_valid),
        .rx_data         (rx_data),
        .prefix_ready    (prefix_ready),
        .pit_out_prefix  (pit_out_prefix),
        .pit_out_metadata(pit_out_metadata),
        .learn_we        (learn_we),
        .learn_len       (learn_len),
        .learn_hash      (learn_hash)
    );

    fib_valid_table u_valid_table (
        .clk    (clk),
        .rst    (rst),
        .we     (learn_we),
        .wr_len (learn_len),
        .wr_hash(learn_hash),
        .rd_len (rd_len),
        .rd_hash(rd_hash),
        .rd_hit (rd_hit)
    );

    fib_lpm_search u_lpm_search (
        .clk            (clk),
        .rst            (rst),
        .lookup_start   (lookup_start),
        .pit_in_prefix  (pit_in_prefix),
        .pit_in_metadata(pit_in_metadata),
        .rd_hit         (rd_hit),
        .tx_done        (tx_done),
        .rd_len         (rd_len),
        .rd_hash        (rd_hash),
        .lookup_busy    (lookup_busy),
        .emit_start     (emit_start),
        .total_prefix   (total_prefix),
        .match_prefix   (match_prefix),
        .match_metadata (match_metadata)
    );

    fib_tx_serializer u_tx_serializer (
        .clk           (clk),
        .rst           (rst),
        .emit_start    (emit_start),
        .total_prefix  (total_prefix),
        .match_prefix  (match_prefix),
        .match_metadata(match_metadata),
        .tx_valid      (tx_valid),
        .tx_data       (tx_data),
        .tx_done       (tx_done)
    );

endmodule

// ==== source/fib_tx_serializer.sv ====
// Lookup reply serializer towards SPI
// Loads metadata, total prefix and matched prefix into one shift register
// Sends 17 bytes back to back, MSB first, done with the last one

`timescale 1ns/1ps

module fib_tx_serializer (
    input  logic             clk,
    input  logic             rst,
    input  logic             emit_start,
    input  fib_pkg::prefix_t total_prefix,
    input  fib_pkg::prefix_t match_prefix,
    input  fib_pkg::byte_t   match_metadata,
    output logic             tx_valid,
    output fib_pkg::byte_t   tx_data,
    output logic             tx_done
);

    import fib_pkg::*;

    localparam int SR_W = BYTE_W * TX_BYTES;

    logic [SR_W-1:0]     shift_r;
    logic [TX_CNT_W-1:0] bytes_left;

    // Remaining byte count, zero means idle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bytes_left <= '0;
        end else if (emit_start) begin
            bytes_left <= TX_CNT_W'(TX_BYTES);
        end else if (bytes_left != '0) begin
            bytes_left <= bytes_left - 1'b1;
        end
    end

    // Reply payload, metadata byte goes out first
    always_ff @(posedge clk) begin
        if (emit_start) begin
            shift_r <= {match_metadata, total_prefix, match_prefix};
        end else if (bytes_left != '0) begin
            shift_r <= shift_r << BYTE_W;
        end
    end

    assign tx_valid = (bytes_left != '0);
    assign tx_data  = shift_r[SR_W-1 -: BYTE_W];
    // Seventeenth byte
    assign tx_done  = (bytes_left == TX_CNT_W'(1));

endmodule

// ==== source/fib_lpm_search.sv ====
// Longest-prefix search engine
// Request capture, hash/check loop over decreasing lengths
// Hands the result to the reply serializer and tracks busy

`timescale 1ns/1ps

module fib_lpm_search (
    input  logic             clk,
    input  logic             rst,
    input  logic             lookup_start,
    input  fib_pkg::prefix_t pit_in_prefix,
    input  fib_pkg::byte_t   pit_in_metadata,
    input  logic             rd_hit,
    input  logic             tx_done,
    output fib_pkg::len_t    rd_len,
    output fib_pkg::hash_t   rd_hash,
    output logic             lookup_busy,
    output logic             emit_start,
    output fib_pkg::prefix_t total_prefix,
    output fib_pkg::prefix_t match_prefix,
    output fib_pkg::byte_t   match_metadata
);

    import fib_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_HASH,
        S_CHECK,
        S_SEND
    } state_t;

    state_t  state;
    prefix_t cur_prefix;
    len_t    cur_len;
    prefix_t total_r;
    byte_t   meta_r;
    logic    accept;
    logic    done_walk;

    assign accept    = (state == S_IDLE) && lookup_start;
    // Stop on a hit or once the length is used up
    assign done_walk = rd_hit || (cur_len == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= S_IDLE;
            emit_start <= 1'b0;
        end else begin
            emit_start <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (lookup_start) begin
                        state <= S_HASH;
                    end
                end
                // Hash of the current candidate lands at the end of this cycle
                S_HASH: state <= S_CHECK;
                S_CHECK: begin
                    if (done_walk) begin
                        emit_start <= 1'b1;
                        state      <= S_SEND;
                    end else begin
                        state <= S_HASH;
                    end
                end
                // Wait for the last reply byte
                S_SEND: begin
                    if (tx_done) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Candidate prefix and length
    always_ff @(posedge clk) begin
        if (accept) begin
            cur_prefix <= pit_in_prefix;
            total_r    <= pit_in_prefix;
            meta_r     <= pit_in_metadata;
            cur_len    <= pit_in_metadata[META_LEN_MSB:META_LEN_LSB];
        end else if (state == S_CHECK && !done_walk) begin
            // Miss, drop the bit at this length and shorten
            cur_prefix[cur_len] <= 1'b0;
            cur_len             <= cur_len - 1'b1;
        end
    end

    fib_prefix_hash u_hash (
        .clk      (clk),
        .rst      (rst),
        .prefix_in(cur_prefix),
        .hash_out (rd_hash)
    );

    assign rd_len         = cur_len;
    assign lookup_busy    = (state != S_IDLE);
    assign total_prefix   = total_r;
    assign match_prefix   = cur_prefix;
    assign match_metadata = meta_r;

    // No new reply may start until the serializer reports its last byte
    a_emit_no_overlap: assert property (@(posedge clk) disable iff (rst)
        emit_start |=> (!emit_start throughout tx_done [->1]))
        else $error("emit_start raised while a reply was still sending");

endmodule

// ==== source/fib_valid_table.sv ====
// Valid-bit array, one row per prefix length, one bit per hash index
// Single write port that only sets bits, combinational read port

`timescale 1ns/1ps

module fib_valid_table (
    input  logic           clk,
    input  logic           rst,
    input  logic           we,
    input  fib_pkg::len_t  wr_len,
    input  fib_pkg::hash_t wr_hash,
    input  fib_pkg::len_t  rd_len,
    input  fib_pkg::hash_t rd_hash,
    output logic           rd_hit
);

    import fib_pkg::*;

    logic [TABLE_DEPTH-1:0] valid_bits [NUM_LENGTHS];

    // Bits are set by learning and only cleared by reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < NUM_LENGTHS; r++) begin
                valid_bits[r] <= '0;
            end
        end else if (we) begin
            valid_bits[wr_len][wr_hash] <= 1'b1;
        end
    end

    // Same-edge write is not visible to this read
    assign rd_hit = valid_bits[rd_len][rd_hash];

    // Learn address must be settled whenever a write is requested
    a_wr_addr_known: assert property (@(posedge clk) disable iff (rst)
        we |-> !$isunknown({wr_len, wr_hash}))
        else $error("valid table write with unknown address");

endmodule

// ==== source/fib_rx_parser.sv ====
// Interest packet parser on the SPI receive side
// Byte counting FSM, prefix shift register, PIT announce pulse
// Learn write request towards the valid-bit table

`timescale 1ns/1ps

module fib_rx_parser (
    input  logic             clk,
    input  logic             rst,
    input  logic             rx_valid,
    input  fib_pkg::byte_t   rx_data,
    output logic             prefix_ready,
    output fib_pkg::prefix_t pit_out_prefix,
    output fib_pkg::byte_t   pit_out_metadata,
    output logic             learn_we,
    output fib_pkg::len_t    learn_len,
    output fib_pkg::hash_t   learn_hash
);

    import fib_pkg::*;

    typedef enum logic [1:0] {
        S_META,
        S_PREFIX,
        S_HASH,
        S_WRITE
    } state_t;

    state_t                  state;
    logic [PREFIX_CNT_W-1:0] byte_cnt;
    prefix_t                 prefix_sr;
    byte_t                   meta_r;
    logic                    last_byte;

    assign last_byte = (state == S_PREFIX) && rx_valid &&
                       (byte_cnt == PREFIX_CNT_W'(PREFIX_BYTES - 1));

    // Control FSM
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= S_META;
            byte_cnt     <= '0;
            prefix_ready <= 1'b0;
            learn_we     <= 1'b0;
        end else begin
            // Announce one cycle after the last byte, write one cycle later
            prefix_ready <= (state == S_HASH);
            learn_we     <= (state == S_WRITE);
            case (state)
                S_META: begin
                    if (rx_valid) begin
                        state    <= S_PREFIX;
                        byte_cnt <= '0;
                    end
                end
                S_PREFIX: begin
                    if (rx_valid) begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                    if (last_byte) begin
                        state <= S_HASH;
                    end
                end
                // Hash unit samples the full prefix here
                S_HASH:  state <= S_WRITE;
                S_WRITE: state <= S_META;
                default: state <= S_META;
            endcase
        end
    end

    // Packet capture, MSB byte first
    always_ff @(posedge clk) begin
        if (rx_valid && state == S_META) begin
            meta_r <= rx_data;
        end
        if (rx_valid && state == S_PREFIX) begin
            prefix_sr <= {prefix_sr[PREFIX_W-BYTE_W-1:0], rx_data};
        end
    end

    // Prefix register stays put until the next packet's prefix bytes
    fib_prefix_hash u_hash (
        .clk      (clk),
        .rst      (rst),
        .prefix_in(prefix_sr),
        .hash_out (learn_hash)
    );

    assign pit_out_prefix   = prefix_sr;
    assign pit_out_metadata = meta_r;
    assign learn_len        = meta_r[META_LEN_MSB:META_LEN_LSB];

    // Sender must leave a two-cycle gap for hashing and the table write
    a_rx_gap: assert property (@(posedge clk) disable iff (rst)
        last_byte |=> !rx_valid [*2])
        else $error("rx_valid asserted while the parser was learning");

endmodule

// ==== source/fib_prefix_hash.sv ====
// Prefix hash unit
// Folds a 64-bit prefix into a 10-bit table index, registered

`timescale 1ns/1ps

module fib_prefix_hash (
    input  logic            clk,
    input  logic            rst,
    input  fib_pkg::prefix_t prefix_in,
    output fib_pkg::hash_t   hash_out
);

    import fib_pkg::*;

    hash_t fold;

    // XOR of 10-bit chunks from bit 0 upward
    // Top chunk only has 4 live bits, the rest reads as zero
    always_comb begin
        fold = '0;
        for (int i = 0; i < PREFIX_W; i++) begin
            fold[i % HASH_W] = fold[i % HASH_W] ^ prefix_in[i];
        end
    end

    // Hash of an input shows up one cycle later
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hash_out <= '0;
        end else begin
            hash_out <= fold;
        end
    end

endmodule

// ==== source/fib_pkg.sv ====
// Shared constants and types for the NDN forwarding table
// Stream, prefix, length and hash widths
// Table geometry and metadata field positions
// Reply length and counter widths

package fib_pkg;

    // Stream and prefix geometry
    localparam int PREFIX_BYTES = 8;
    localparam int BYTE_W       = 8;
    localparam int PREFIX_W     = PREFIX_BYTES * BYTE_W;

    // Prefix length field, one table row per possible length
    localparam int LEN_W       = 6;
    localparam int NUM_LENGTHS = 1 << LEN_W;

    // Table index width and bits per row
    localparam int HASH_W      = 10;
    localparam int TABLE_DEPTH = 1 << HASH_W;

    // Length field inside the metadata byte
    // Bit 6 flags an interest packet, carried through unchanged
    localparam int META_LEN_LSB = 0;
    localparam int META_LEN_MSB = 5;

    // Reply is metadata, total prefix, matched prefix
    localparam int TX_BYTES = 1 + 2 * PREFIX_BYTES;

    // Counter widths derived from the byte counts
    localparam int PREFIX_CNT_W = $clog2(PREFIX_BYTES);
    localparam int TX_CNT_W     = $clog2(TX_BYTES + 1);

    typedef logic [PREFIX_W-1:0] prefix_t;
    typedef logic [BYTE_W-1:0]   byte_t;
    typedef logic [LEN_W-1:0]    len_t;
    typedef logic [HASH_W-1:0]   hash_t;

endpackage
